// File: src/isaPkg.sv
package isaPkg;

	// --------------------------------------------------
	// instruction and control word sizes
	// --------------------------------------------------
	localparam int instrWidth = 16;
	localparam int decodedWidth = 16;

	// operand selector widths
	localparam int srcWidth = 2;
	localparam int destWidth = 1;
	localparam int regAddrWidth = 4;

	// control field sits above srcA, srcB and dest
	localparam int controlOffset = 2 * srcWidth + destWidth;
	localparam int controlWidth = decodedWidth - controlOffset;

	// opcode bits 11..5, the rest of the word is free space
	localparam int opcodeWidth = 7;
	localparam int spareWidth = instrWidth - controlOffset - opcodeWidth;

	// low five bits, same place in instruction and decoded word
	typedef struct packed {
		logic [destWidth-1:0] dest;
		logic [srcWidth-1:0] srcB;
		logic [srcWidth-1:0] srcA;
	} operandT;

	// memory view
	// R | load code | store code | dest | srcB | srcA
	typedef struct packed {
		logic [spareWidth-1:0] spare;
		logic isReg;
		logic [2:0] loadCode;
		logic [2:0] storeCode;
		operandT operand;
	} memViewT;

	// register view
	// R | P | read address | write address | srcA
	typedef struct packed {
		logic [spareWidth-1:0] spare;
		logic isReg;
		logic parallel;
		logic [regAddrWidth-1:0] readAddr;
		logic [regAddrWidth-1:0] writeAddr;
		logic [srcWidth-1:0] srcA;
	} regViewT;

	// one instruction word, two readings
	typedef union packed {
		memViewT memView;
		regViewT regView;
	} instrU;

	typedef logic [decodedWidth-1:0] decodedT;

endpackage

// File: src/unitPkg.sv
package unitPkg;

	// --------------------------------------------------
	// unit types served by the decoder
	// --------------------------------------------------
	localparam int unitTypeWidth = 3;

	// codes 3 to 7 have no decoder and give a zero word
	typedef enum logic [unitTypeWidth-1:0] {
		Lsu = 3'd0,
		Rf = 3'd1,
		Alu = 3'd2
	} unitT;

	// config word layout
	// unit type at the bottom, stall group right above
	localparam int unitTypeLsb = 0;
	localparam int stallGroupLsb = unitTypeLsb + unitTypeWidth;

	// --------------------------------------------------
	// idle control fields
	// --------------------------------------------------
	// alu at rest keeps control bits 7 and 6 high
	localparam logic [isaPkg::controlWidth-1:0] aluIdleControl = 11'b000_1100_0000;
	// all other units idle at zero
	localparam logic [isaPkg::controlWidth-1:0] zeroIdleControl = '0;

endpackage

// File: src/configChain.sv
`timescale 1ns/1ps

module configChain import unitPkg::*;
#(
	parameter int numStallGroups = 4,
	localparam int stallGroupWidth =
		($clog2(numStallGroups) > 1) ? $clog2(numStallGroups) : 1
)
(
	input logic iClk,
	input logic iConfigEnable,
	input logic iConfigDataIn,
	output logic oConfigDataOut,
	output unitT unitType,
	output logic [stallGroupWidth-1:0] stallGroup
);

	localparam int configWidth = stallGroupLsb + stallGroupWidth;

	// scan register, loaded serially while in reset
	logic [configWidth-1:0] configReg;

	// shift right, new bit enters at the top
	always_ff @(posedge iClk)
	begin
		if (iConfigEnable)
		begin
			configReg <= {iConfigDataIn, configReg[configWidth-1:1]};
		end
	end

	// serial out for the next element of the chain
	assign oConfigDataOut = configReg[0];

	// field split
	assign unitType = unitT'(configReg[unitTypeLsb +: unitTypeWidth]);
	assign stallGroup = configReg[stallGroupLsb +: stallGroupWidth];

endmodule

// File: src/lsuDecoder.sv
`timescale 1ns/1ps

module lsuDecoder import isaPkg::*;
(
	input instrU instr,
	output decodedT decoded
);

	// register bits that fit above the write-immediate flag
	localparam int lsuRegBits = regAddrWidth - destWidth - srcWidth;

	logic [4:0] memCode;
	logic [7:0] lsEnables;
	logic isRegOp;

	// R, load code and top store bit
	assign memCode = {instr.memView.isReg, instr.memView.loadCode, instr.memView.storeCode[2]};

	// 10000 and 10100 are register moves, not memory access
	assign isRegOp = (memCode == 5'b10000) || (memCode == 5'b10100);

	// --------------------------------------------------
	// one-hot load/store enables
	// --------------------------------------------------
	// lgi lg li l | sgi sg si s
	always_comb
	begin
		case (memCode)
			5'b00001: lsEnables = 8'b0000_0001;
			5'b00010: lsEnables = 8'b0000_0010;
			5'b00011: lsEnables = 8'b0000_0100;
			5'b00101: lsEnables = 8'b0001_0000;
			5'b00110: lsEnables = 8'b0010_0000;
			5'b00111: lsEnables = 8'b0100_0000;
			5'b01000: lsEnables = 8'b1000_0000;
			5'b01001: lsEnables = 8'b0010_0001;
			5'b01010: lsEnables = 8'b1000_0001;
			5'b01011: lsEnables = 8'b0001_0010;
			5'b01100: lsEnables = 8'b0010_0010;
			5'b01101: lsEnables = 8'b0100_0010;
			5'b01110: lsEnables = 8'b1000_0010;
			5'b01111: lsEnables = 8'b0010_0100;
			5'b10001: lsEnables = 8'b1000_0100;
			5'b10010: lsEnables = 8'b0001_1000;
			5'b10011: lsEnables = 8'b0010_1000;
			5'b10101: lsEnables = 8'b1000_1000;
			5'b10110: lsEnables = 8'b0000_1000;
			5'b10111: lsEnables = 8'b0100_1000;
			// nop, 00100 and register moves
			default: lsEnables = 8'b0000_0000;
		endcase
	end

	// --------------------------------------------------
	// word assembly
	// --------------------------------------------------
	always_comb
	begin
		decoded = '0;
		decoded[controlOffset-1:0] = instr.memView.operand;
		if (!isRegOp)
		begin
			// low store bits pass straight through
			decoded[controlOffset+10 -: 2] = instr.memView.storeCode[1:0];
			// 00100 writes the immediate register
			decoded[controlOffset+8] = (memCode == 5'b00100);
			decoded[controlOffset +: 8] = lsEnables;
		end
		else
		begin
			// both register moves write the immediate register
			decoded[controlOffset+8] = 1'b1;
			// 0100 also enables register loading
			decoded[controlOffset+4] = memCode[2];
			// top write address bit lands at bit 14
			decoded[controlOffset+9 +: lsuRegBits] =
				instr.regView.writeAddr[regAddrWidth-1 -: lsuRegBits];
		end
	end

endmodule

// File: src/rfDecoder.sv
`timescale 1ns/1ps

module rfDecoder import isaPkg::*;
(
	input instrU instr,
	output decodedT decoded
);

	// read, read imm, write, write imm
	localparam int rfCtrlWidth = 4;

	logic [rfCtrlWidth-1:0] singleCtrl;

	// single register ops reuse the read address field as sub-opcode
	always_comb
	begin
		case (instr.regView.readAddr)
			4'b0000: singleCtrl = 4'b0001;
			4'b1000: singleCtrl = 4'b0100;
			4'b0100: singleCtrl = 4'b0010;
			4'b0010: singleCtrl = 4'b1000;
			default: singleCtrl = 4'b0000;
		endcase
	end

	// --------------------------------------------------
	// word assembly
	// --------------------------------------------------
	always_comb
	begin
		// lower half of the space is a nop for the register file
		decoded = '0;
		if (instr.regView.isReg)
		begin
			decoded[controlOffset-1:0] = instr.memView.operand;
			if (!instr.regView.parallel)
			begin
				decoded[controlOffset +: rfCtrlWidth] = singleCtrl;
				decoded[controlOffset+rfCtrlWidth +: regAddrWidth] = instr.regView.writeAddr;
			end
			else
			begin
				// parallel load and store
				decoded[controlOffset +: rfCtrlWidth] = 4'b0101;
				// low write bits already sit in dest and srcB
				decoded[controlOffset+rfCtrlWidth +: regAddrWidth+1] =
					{instr.regView.readAddr, instr.regView.writeAddr[regAddrWidth-1]};
			end
		end
	end

endmodule

// File: src/aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder import isaPkg::*;
(
	input instrU instr,
	output decodedT decoded
);

	logic [opcodeWidth-1:0] opcode;
	logic [2:0] opTop;
	logic [3:0] opLow;
	logic [4:0] expanded;
	logic opValid;
	logic signExt;

	// opcode occupies bits 11..5
	assign opcode = {instr.memView.isReg, instr.memView.loadCode, instr.memView.storeCode};
	assign opTop = opcode[6:4];
	assign opLow = opcode[3:0];

	// zero opcode is a nop with an unbuffered dest
	assign opValid = (opcode != '0);

	// --------------------------------------------------
	// 3 to 5 control expansion
	// --------------------------------------------------
	// shiftA_L, isCmov, isSigned, invert, eq_lt
	always_comb
	begin
		case (opTop)
			3'b000: expanded = 5'b11000;
			3'b001: expanded = 5'b00000;
			3'b010: expanded = 5'b10110;
			3'b011: expanded = 5'b00010;
			3'b100: expanded = 5'b00100;
			3'b101: expanded = 5'b10011;
			3'b110: expanded = 5'b00001;
			default: expanded = 5'b01000;
		endcase
	end

	// add/sub class or pass, under a signed or compare top code
	assign signExt = ((opLow[3:2] == 2'b10) || (opLow == 4'b0011))
		&& (opTop inside {3'b010, 3'b110, 3'b101, 3'b100});

	// sign ext | valid | control | type and operation | operand
	assign decoded = {
		signExt,
		opValid,
		expanded,
		opLow,
		opValid ? instr.memView.operand.dest : {destWidth{1'b0}},
		instr.memView.operand.srcB,
		instr.memView.operand.srcA
	};

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import isaPkg::*, unitPkg::*;
#(
	parameter int numStallGroups = 4,
	localparam int stallGroupWidth =
		($clog2(numStallGroups) > 1) ? $clog2(numStallGroups) : 1
)
(
	input logic iClk,
	input logic rst,
	input logic [numStallGroups-1:0] iStall,
	input logic [stallGroupWidth-1:0] stallGroup,
	input unitT unitType,
	input decodedT lsuWord,
	input decodedT rfWord,
	input decodedT aluWord,
	output decodedT oDecodedInstruction
);

	logic stallReg;
	decodedT decodedReg;
	decodedT selectedWord;
	logic [controlWidth-1:0] idleControl;

	// pick the decoder for the configured unit
	always_comb
	begin
		case (unitType)
			Lsu: selectedWord = lsuWord;
			Rf: selectedWord = rfWord;
			Alu: selectedWord = aluWord;
			default: selectedWord = '0;
		endcase
	end

	assign idleControl = (unitType == Alu) ? aluIdleControl : zeroIdleControl;

	// --------------------------------------------------
	// stall and decode registers
	// --------------------------------------------------
	// one cycle of stall latency
	always_ff @(posedge iClk)
	begin
		if (rst)
			stallReg <= 1'b0;
		else
			stallReg <= iStall[stallGroup];
	end

	// hold while stalled
	always_ff @(posedge iClk)
	begin
		if (rst)
			decodedReg <= {idleControl, {controlOffset{1'b0}}};
		else if (!stallReg)
			decodedReg <= selectedWord;
	end

	// output forms
	always_comb
	begin
		if (rst)
			oDecodedInstruction = '0;
		else if (stallReg)
			// operands stay visible, control goes idle
			oDecodedInstruction = {idleControl, decodedReg[controlOffset-1:0]};
		else
			oDecodedInstruction = decodedReg;
	end

endmodule

// File: src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import isaPkg::*, unitPkg::*;
#(
	parameter int numStallGroups = 4,
	localparam int stallGroupWidth =
		($clog2(numStallGroups) > 1) ? $clog2(numStallGroups) : 1
)
(
	input logic iClk,
	input logic rst,
	input logic [numStallGroups-1:0] iStall,
	input logic iConfigEnable,
	input logic iConfigDataIn,
	input logic [instrWidth-1:0] iInstruction,
	output logic oConfigDataOut,
	output logic [decodedWidth-1:0] oDecodedInstruction
);

	unitT unitType;
	logic [stallGroupWidth-1:0] stallGroup;
	decodedT lsuWord;
	decodedT rfWord;
	decodedT aluWord;

	// --------------------------------------------------
	// configuration
	// --------------------------------------------------
	configChain #(
		.numStallGroups(numStallGroups)
	) i_configChain (
		.iClk(iClk),
		.iConfigEnable(iConfigEnable),
		.iConfigDataIn(iConfigDataIn),
		.oConfigDataOut(oConfigDataOut),
		.unitType(unitType),
		.stallGroup(stallGroup)
	);

	// --------------------------------------------------
	// per-unit decoders, all see the same instruction
	// --------------------------------------------------
	lsuDecoder i_lsuDecoder (
		.instr(iInstruction),
		.decoded(lsuWord)
	);

	rfDecoder i_rfDecoder (
		.instr(iInstruction),
		.decoded(rfWord)
	);

	aluDecoder i_aluDecoder (
		.instr(iInstruction),
		.decoded(aluWord)
	);

	// select, register and stall handling
	decodeStage #(
		.numStallGroups(numStallGroups)
	) i_decodeStage (
		.iClk(iClk),
		.rst(rst),
		.iStall(iStall),
		.stallGroup(stallGroup),
		.unitType(unitType),
		.lsuWord(lsuWord),
		.rfWord(rfWord),
		.aluWord(aluWord),
		.oDecodedInstruction(oDecodedInstruction)
	);

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ps

module tbClock
#(
	parameter int halfPeriod = 10,
	parameter int resetCycles = 4
)
(
	output logic iClk,
	output logic rst
);

	// free running clock
	initial
	begin
		iClk = 1'b0;
		forever #(halfPeriod) iClk = ~iClk;
	end

	// reset held for a fixed number of rising edges, released just after one
	initial
	begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge iClk);
		#1;
		rst = 1'b0;
	end

endmodule

// File: tb/instrDecoderTb.sv
`timescale 1ns/1ps

module instrDecoderTb import isaPkg::*, unitPkg::*;
();

	localparam int numStallGroups = 4;
	localparam int clkPeriod = 20;
	localparam int resetCycles = 4;
	localparam int randomCount = 300;
	// five shifts plus one reset edge with the final config
	localparam int configCycles = 6;
	localparam int stallCycles = 10;
	localparam int cyclesPerUnit = configCycles + randomCount + stallCycles;
	localparam int totalCycles = resetCycles + 1 + 3 * cyclesPerUnit;
	localparam int marginNs = 2000;
	localparam int timeoutNs = totalCycles * clkPeriod + marginNs;
	// selected stall line per cycle of the stall phase from the lsb up
	localparam logic [stallCycles-1:0] stallShape = 10'b00_0011_0111;

	logic iClk;
	wire genRst;
	logic localRst;
	wire rst;
	logic [numStallGroups-1:0] iStall;
	logic iConfigEnable;
	logic iConfigDataIn;
	logic [instrWidth-1:0] iInstruction;
	wire oConfigDataOut;
	wire [decodedWidth-1:0] oDecodedInstruction;

	// testbench view of the configuration
	unitT cfgUnit;
	logic [1:0] cfgGroup;
	logic [4:0] prevWord;
	logic cfgLoaded;
	logic [31:0] rngState;

	// model of the decode stage
	logic modelStall;
	decodedT modelReg;
	decodedT expectedWord;

	assign rst = genRst | localRst;

	tbClock #(
		.halfPeriod(clkPeriod / 2),
		.resetCycles(resetCycles)
	) i_tbClock (
		.iClk(iClk),
		.rst(genRst)
	);

	instrDecoder #(
		.numStallGroups(numStallGroups)
	) i_instrDecoder (
		.iClk(iClk),
		.rst(rst),
		.iStall(iStall),
		.iConfigEnable(iConfigEnable),
		.iConfigDataIn(iConfigDataIn),
		.iInstruction(iInstruction),
		.oConfigDataOut(oConfigDataOut),
		.oDecodedInstruction(oDecodedInstruction)
	);

	// --------------------------------------------------
	// reference decode
	// --------------------------------------------------
	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// one-hot load/store enables by 5-bit memory code
	function automatic logic [7:0] lsuTable(input logic [4:0] code);
		case (code)
			5'h01: return 8'h01;
			5'h02: return 8'h02;
			5'h03: return 8'h04;
			5'h05: return 8'h10;
			5'h06: return 8'h20;
			5'h07: return 8'h40;
			5'h08: return 8'h80;
			5'h09: return 8'h21;
			5'h0A: return 8'h81;
			5'h0B: return 8'h12;
			5'h0C: return 8'h22;
			5'h0D: return 8'h42;
			5'h0E: return 8'h82;
			5'h0F: return 8'h24;
			5'h11: return 8'h84;
			5'h12: return 8'h18;
			5'h13: return 8'h28;
			5'h15: return 8'h88;
			5'h16: return 8'h08;
			5'h17: return 8'h48;
			default: return 8'h00;
		endcase
	endfunction

	function automatic decodedT lsuRef(input logic [15:0] in);
		decodedT word;
		logic [4:0] code;
		code = in[11:7];
		word = {11'b0, in[4:0]};
		if (code == 5'h10 || code == 5'h14)
		begin
			// register moves
			word[13] = 1'b1;
			word[9] = in[9];
			word[14] = in[5];
		end
		else
		begin
			word[15:14] = in[6:5];
			word[13] = (code == 5'h04);
			word[12:5] = lsuTable(code);
		end
		return word;
	endfunction

	function automatic decodedT rfRef(input logic [15:0] in);
		decodedT word;
		logic [3:0] ctl;
		word = '0;
		if (in[11])
		begin
			word[4:0] = in[4:0];
			if (!in[10])
			begin
				case (in[9:6])
					4'h0: ctl = 4'b0001;
					4'h8: ctl = 4'b0100;
					4'h4: ctl = 4'b0010;
					4'h2: ctl = 4'b1000;
					default: ctl = 4'b0000;
				endcase
				word[8:5] = ctl;
				word[12:9] = in[5:2];
			end
			else
			begin
				// parallel load/store
				word[8:5] = 4'b0101;
				word[13:9] = in[9:5];
			end
		end
		return word;
	endfunction

	function automatic logic [4:0] aluExpand(input logic [2:0] top);
		case (top)
			3'd0: return 5'h18;
			3'd1: return 5'h00;
			3'd2: return 5'h16;
			3'd3: return 5'h02;
			3'd4: return 5'h04;
			3'd5: return 5'h13;
			3'd6: return 5'h01;
			default: return 5'h08;
		endcase
	endfunction

	function automatic decodedT aluRef(input logic [15:0] in);
		logic [2:0] top;
		logic [3:0] low;
		logic valid;
		logic sx;
		top = in[11:9];
		low = in[8:5];
		valid = (in[11:5] != 7'd0);
		sx = ((low[3:2] == 2'b10) || (low == 4'h3))
			&& (top == 3'd2 || top == 3'd6 || top == 3'd5 || top == 3'd4);
		return {sx, valid, aluExpand(top), low, in[4] & valid, in[3:0]};
	endfunction

	function automatic decodedT refDecode(input unitT unit, input logic [15:0] in);
		case (unit)
			Lsu: return lsuRef(in);
			Rf: return rfRef(in);
			Alu: return aluRef(in);
			default: return '0;
		endcase
	endfunction

	// reset word and control part of the stalled form
	function automatic decodedT idleWord(input unitT unit);
		return (unit == Alu) ? 16'h1800 : 16'h0000;
	endfunction

	// --------------------------------------------------
	// checking
	// --------------------------------------------------
	task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Fail %0t ns: %s got %h expected %h", $time, what, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	// stall register and decoded register one cycle behind the inputs
	always @(posedge iClk)
	begin
		if (rst)
		begin
			modelStall <= 1'b0;
			modelReg <= idleWord(cfgUnit);
		end
		else
		begin
			modelStall <= iStall[cfgGroup];
			if (!modelStall)
				modelReg <= refDecode(cfgUnit, iInstruction);
		end
	end

	// compare mid-cycle once the clock runs
	initial
	begin
		@(posedge iClk);
		forever
		begin
			@(negedge iClk);
			if (rst)
				expectedWord = '0;
			else if (modelStall)
				expectedWord = idleWord(cfgUnit) | {11'b0, modelReg[4:0]};
			else
				expectedWord = modelReg;
			checkValue(oDecodedInstruction, expectedWord, "decoded word");
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	// shift a new config under reset while the old word comes out lsb first
	task automatic configure(input unitT unit, input logic [1:0] group);
		logic [4:0] word;
		int k;
		word = {group, 3'(unit)};
		localRst = 1'b1;
		iStall = '0;
		cfgUnit = unit;
		cfgGroup = group;
		for (k = 0; k < 5; k++)
		begin
			if (cfgLoaded)
				checkValue({15'b0, oConfigDataOut}, {15'b0, prevWord[k]}, "config serial out");
			iConfigEnable = 1'b1;
			iConfigDataIn = word[k];
			@(posedge iClk);
			#1;
		end
		iConfigEnable = 1'b0;
		iConfigDataIn = 1'b0;
		// one more reset edge so the reset word sees the new unit type
		@(posedge iClk);
		#1;
		localRst = 1'b0;
		prevWord = word;
		cfgLoaded = 1'b1;
	endtask

	task automatic runUnit(input unitT unit, input logic [1:0] group);
		int k;
		configure(unit, group);
		// random instructions while only unselected stall lines toggle
		for (k = 0; k < randomCount; k++)
		begin
			rngState = lcgStep(rngState);
			iInstruction = rngState[31:16];
			iStall = rngState[11:8] & ~(4'b1 << group);
			@(posedge iClk);
			#1;
		end
		// selected stall line, held word and idle form
		for (k = 0; k < stallCycles; k++)
		begin
			rngState = lcgStep(rngState);
			iInstruction = rngState[31:16];
			iStall = stallShape[k] ? (4'b1 << group) : 4'b0;
			@(posedge iClk);
			#1;
		end
		iStall = '0;
	endtask

	initial
	begin
		localRst = 1'b1;
		iStall = '0;
		iConfigEnable = 1'b0;
		iConfigDataIn = 1'b0;
		iInstruction = '0;
		rngState = 32'h661f_f7d1;
		cfgUnit = Lsu;
		cfgGroup = 2'd0;
		prevWord = '0;
		cfgLoaded = 1'b0;
		@(posedge iClk);
		#1;
		runUnit(Lsu, 2'd1);
		runUnit(Rf, 2'd3);
		runUnit(Alu, 2'd0);
		$display("NO ERRORS");
		$finish;
	end

	// watchdog sized from the test length
	initial
	begin
		#(timeoutNs);
		$display("timeout: the test sequence did not complete in time");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: instrDecoder.f
src/isaPkg.sv
src/unitPkg.sv
src/configChain.sv
src/lsuDecoder.sv
src/rfDecoder.sv
src/aluDecoder.sv
src/decodeStage.sv
src/instrDecoder.sv
tb/tbClock.sv
tb/instrDecoderTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= instrDecoderTb
RTL_TOP   ?= instrDecoder
FILELIST  ?= instrDecoder.f
EXE       ?= simv
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(FLAGS) --lint-only -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) --binary -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(EXE)
	./$(OBJ_DIR)/$(EXE)

clean:
	rm -rf $(OBJ_DIR)
